// ==== rv_priv.f ====
+incdir+design
design/rv32i_types_pkg.sv
design/machine_mode_types_pkg.sv
design/csr_counter64.sv
design/csr_rfile.sv
design/prv_control.sv
design/prv_block.sv
dv/prv_block_tb.sv

// ==== dv/prv_stimulus.txt ====
// op addr/mask data expected, all hex, one operation per line
// op: 0 test end, 1 swap, 2 set, 3 clear, 4 read, 5 invalid address, 6 idle cycles,
//     7 fault mask, 8 mret, 9 retire pulses, a wait for interrupt, b interrupt stays low,
//     c cycle delta, d load without check, e random read-modify-write
4 f00 00000000 00000100
4 f10 00000000 00000000
1 301 deadbeef 000001c0
4 301 00000000 000001c0
1 f00 ffffffff 00000100
4 f00 00000000 00000100
2 f10 00000005 00000000
4 f10 00000000 00000000
5 123 00000000 00000000
0 001 00000000 00000000
1 340 12345678 00000000
2 340 0f0f0000 12345678
3 340 0000ff00 1f3f5678
4 340 00000000 1f3f0078
e 340 00000006 1f3f0078
0 002 00000000 00000000
c c00 00000007 00000007
9 000 00000005 00000000
4 c02 00000000 00000005
4 c82 00000000 00000000
d 701 00010000 00000000
6 000 00000001 00000000
4 c01 00000000 00010001
0 003 00000000 00000000
1 321 00002000 00000000
d 701 00001ffc 00000000
b 000 00000008 00000000
4 344 00000000 00000080
2 304 00000080 00000000
a 000 00000004 000001c0
4 342 00000000 80000007
4 300 00000000 00000db6
1 321 00003000 00002000
4 344 00000000 00000000
3 304 00000080 00000080
0 004 00000000 00000000
7 064 00001000 000001c0
4 342 00000000 00000002
4 341 00000000 00001000
4 343 00000000 00000000
7 0e0 00002004 000001c0
4 342 00000000 00000005
4 341 00000000 00002004
4 343 00000000 ffff2004
7 110 0000400c 000001c0
4 342 00000000 0000000b
4 341 00000000 0000400c
4 343 00000000 ffff2004
0 005 00000000 00000000
8 000 00000000 0000400c
4 300 00000000 00000db7
0 006 00000000 00000000

// ==== dv/prv_block_tb.sv ====
// Testbench for the privilege unit top level
//   operations and expected values loaded from dv/prv_stimulus.txt
//   CSR, fault, mret and retire drivers on falling edges
//   per-test report, closing counts and a watchdog

`timescale 1ns/1ps
`default_nettype none

module prv_block_tb
  import rv32i_types_pkg::*;
();

  localparam int MAX_OPS = 64;
  localparam logic [3:0] OP_END         = 4'h0;
  localparam logic [3:0] OP_SWAP        = 4'h1;
  localparam logic [3:0] OP_SET         = 4'h2;
  localparam logic [3:0] OP_CLR         = 4'h3;
  localparam logic [3:0] OP_READ        = 4'h4;
  localparam logic [3:0] OP_INVALID     = 4'h5;
  localparam logic [3:0] OP_IDLE        = 4'h6;
  localparam logic [3:0] OP_FAULT       = 4'h7;
  localparam logic [3:0] OP_MRET        = 4'h8;
  localparam logic [3:0] OP_RETIRE      = 4'h9;
  localparam logic [3:0] OP_WAIT_INTR   = 4'ha;
  localparam logic [3:0] OP_NO_INTR     = 4'hb;
  localparam logic [3:0] OP_CYCLE_DELTA = 4'hc;
  localparam logic [3:0] OP_LOAD        = 4'hd;
  localparam logic [3:0] OP_RANDOM      = 4'he;

  logic        CLK, nRST;
  logic [11:0] csr_addr;
  logic        csr_swap, csr_set, csr_clr;
  word_t       csr_wdata, csr_rdata;
  logic        invalid_csr, instr_retired;
  logic        mal_insn, fault_insn, illegal_insn, breakpoint;
  logic        mal_l, fault_l, mal_s, fault_s, env_m;
  word_t       epc, badaddr, priv_pc;
  logic        mret, soft_int, insert_pc, intr;

  logic [31:0] stim [0:4*MAX_OPS-1]; // Four words per operation
  integer      seed = 32'h80b5adf6;
  int          n_ops;
  int          checks, errors, test_checks, test_errors;

  prv_block prv_block_i (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic idle_inputs();
    csr_addr      = '0;
    {csr_swap, csr_set, csr_clr} = 3'b000;
    csr_wdata     = '0;
    instr_retired = 1'b0;
    {env_m, fault_s, mal_s, fault_l, mal_l} = 5'b0;
    {breakpoint, illegal_insn, fault_insn, mal_insn} = 4'b0;
    epc           = '0;
    badaddr       = '0;
    mret          = 1'b0;
    soft_int      = 1'b0;
  endtask

  task automatic idle_cycle();
    @(negedge CLK);
    idle_inputs();
    #2;
  endtask

  task automatic count_failure();
    errors++;
    test_errors++;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    test_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      count_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    test_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      count_failure();
    end
  endtask

  // kind 1 swap, 2 set, 3 clear; set with zero is a plain read
  task automatic csr_access(input logic [1:0] kind, input logic [11:0] addr, input word_t wdata);
    @(negedge CLK);
    idle_inputs();
    csr_addr  = addr;
    csr_wdata = wdata;
    csr_swap  = (kind == 2'd1);
    csr_set   = (kind == 2'd2);
    csr_clr   = (kind == 2'd3);
    #2; // Read data is combinational
  endtask

  task automatic raise_faults(input logic [8:0] mask, input word_t pc);
    @(negedge CLK);
    idle_inputs();
    {env_m, fault_s, mal_s, fault_l, mal_l, breakpoint, illegal_insn, fault_insn, mal_insn} = mask;
    epc     = pc;
    badaddr = pc ^ 32'hffff_0000; // Distinct from epc
    #2;
  endtask

  task automatic wait_for_intr(input int max_cycles, output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < max_cycles) begin
      idle_cycle();
      seen = intr;
      n++;
    end
  endtask

  // Model follows swap, set and clear on random words
  task automatic random_rmw(input logic [11:0] addr, input int rounds, input word_t start);
    word_t model;
    word_t r;
    model = start;
    for (int k = 0; k < rounds; k++) begin
      r = $random(seed);
      csr_access(2'(1 + k % 3), addr, r);
      check_word("csr_rdata", csr_rdata, model);
      case (k % 3)
        0: model = r;
        1: model = model | r;
        default: model = model & ~r;
      endcase
    end
    csr_access(2'd2, addr, '0);
    check_word("csr_rdata", csr_rdata, model);
  endtask

  initial begin : stimulus
    logic [3:0] op;
    word_t      sel, data, exp, first;
    logic       seen;
    idle_inputs();
    nRST = 1'b0;
    $readmemh("dv/prv_stimulus.txt", stim);
    n_ops = 0;
    while (n_ops < MAX_OPS && !$isunknown(stim[4*n_ops])) n_ops++;
    if (n_ops == 0) begin
      $display("No operations could be read from the stimulus file");
      errors++;
    end
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    for (int i = 0; i < n_ops; i++) begin
      op   = stim[4*i][3:0];
      sel  = stim[4*i+1];
      data = stim[4*i+2];
      exp  = stim[4*i+3];
      case (op)
        OP_END: begin
          $display("Test %0d: %0d checks, %0d errors", sel, test_checks, test_errors);
          test_checks = 0;
          test_errors = 0;
        end
        OP_SWAP, OP_SET, OP_CLR: begin
          csr_access(op[1:0], sel[11:0], data);
          check_word("csr_rdata", csr_rdata, exp); // Old value
          check_bit("invalid_csr", invalid_csr, 1'b0);
        end
        OP_READ: begin
          csr_access(2'd2, sel[11:0], '0);
          check_word("csr_rdata", csr_rdata, exp);
          check_bit("invalid_csr", invalid_csr, 1'b0);
        end
        OP_INVALID: begin
          csr_access(2'd2, sel[11:0], '0);
          check_bit("invalid_csr", invalid_csr, 1'b1);
          check_word("csr_rdata", csr_rdata, exp);
        end
        OP_IDLE: repeat (data) idle_cycle();
        OP_FAULT: begin
          raise_faults(sel[8:0], data);
          check_bit("insert_pc", insert_pc, 1'b1);
          check_bit("intr", intr, 1'b0);
          check_word("priv_pc", priv_pc, exp);
        end
        OP_MRET: begin
          @(negedge CLK);
          idle_inputs();
          mret = 1'b1;
          #2;
          check_bit("insert_pc", insert_pc, 1'b1);
          check_word("priv_pc", priv_pc, exp);
        end
        OP_RETIRE: begin
          repeat (data) begin
            @(negedge CLK);
            idle_inputs();
            instr_retired = 1'b1;
          end
        end
        OP_WAIT_INTR: begin
          wait_for_intr(data, seen);
          checks++;
          test_checks++;
          assert (seen) else begin
            $display("Interrupt was not taken within %0d cycles", data);
            count_failure();
          end
          check_bit("insert_pc", insert_pc, 1'b1);
          check_word("priv_pc", priv_pc, exp);
        end
        OP_NO_INTR: begin
          repeat (data) begin
            idle_cycle();
            check_bit("intr", intr, 1'b0);
            check_bit("insert_pc", insert_pc, 1'b0);
          end
        end
        OP_CYCLE_DELTA: begin
          csr_access(2'd2, sel[11:0], '0);
          first = csr_rdata;
          repeat (data - 1) idle_cycle();
          csr_access(2'd2, sel[11:0], '0);
          check_word("csr_rdata delta", csr_rdata - first, exp);
        end
        OP_LOAD:   csr_access(2'd1, sel[11:0], data);
        OP_RANDOM: random_rmw(sel[11:0], data, exp);
        default: begin
          $display("Unknown operation code %h on stimulus line %0d", op, i);
          count_failure();
        end
      endcase
    end
    idle_cycle();
    $display("Checks: %0d run, %0d failed", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Budget grows with the number of operations
  initial begin : watchdog
    int limit;
    wait (nRST === 1'b1);
    limit = n_ops * 20 + 200;
    repeat (limit) @(posedge CLK);
    $display("Run did not finish within %0d cycles", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/prv_block.sv ====
// Privilege unit top level
//   csr_rfile holds the machine CSRs and counters
//   prv_control raises traps and redirects the pipeline

`timescale 1ns/1ps
`default_nettype none

module prv_block
  import rv32i_types_pkg::*, machine_mode_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t csr_addr,
  input  logic      csr_swap,
  input  logic      csr_set,
  input  logic      csr_clr,
  input  word_t     csr_wdata,
  output word_t     csr_rdata,
  output logic      invalid_csr,
  input  logic      instr_retired,
  input  logic      mal_insn,
  input  logic      fault_insn,
  input  logic      illegal_insn,
  input  logic      breakpoint,
  input  logic      mal_l,
  input  logic      fault_l,
  input  logic      mal_s,
  input  logic      fault_s,
  input  logic      env_m,
  input  word_t     epc,
  input  word_t     badaddr,
  input  logic      mret,
  input  logic      soft_int,
  output logic      insert_pc,
  output word_t     priv_pc,
  output logic      intr
);

  mstatus_t mstatus, mstatus_next;
  mie_t     mie;
  mip_t     mip, mip_next;
  mcause_t  mcause_next;
  word_t    mepc, mepc_next, mtvec, mbadaddr_next;
  logic     timer_int;
  logic     mstatus_rup, mepc_rup, mcause_rup, mbadaddr_rup, mip_rup;

  csr_rfile csr_rfile_i (.*);

  prv_control prv_control_i (.*);

endmodule

`default_nettype wire

// ==== design/prv_control.sv ====
// Machine mode trap control
//   pending interrupt tracking for mip
//   exception priority and interrupt selection
//   mepc/mcause/mbadaddr/mstatus update strobes
//   PC redirect for traps and mret

`timescale 1ns/1ps
`default_nettype none

module prv_control
  import rv32i_types_pkg::*, machine_mode_types_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     mal_insn,
  input  logic     fault_insn,
  input  logic     illegal_insn,
  input  logic     breakpoint,
  input  logic     mal_l,
  input  logic     fault_l,
  input  logic     mal_s,
  input  logic     fault_s,
  input  logic     env_m,
  input  logic     mret,
  input  logic     soft_int,
  input  word_t    epc,
  input  word_t    badaddr,
  input  logic     timer_int,
  input  mstatus_t mstatus,
  input  mie_t     mie,
  input  mip_t     mip,
  input  word_t    mepc,
  input  word_t    mtvec,
  output logic     mstatus_rup,
  output mstatus_t mstatus_next,
  output logic     mepc_rup,
  output word_t    mepc_next,
  output logic     mcause_rup,
  output mcause_t  mcause_next,
  output logic     mbadaddr_rup,
  output word_t    mbadaddr_next,
  output logic     mip_rup,
  output mip_t     mip_next,
  output logic     insert_pc,
  output word_t    priv_pc,
  output logic     intr
);

  logic      exception;
  logic      addr_fault; // Cause carries a bad address
  logic      int_pend;
  logic      trap;
  ex_code_e  ex_code;
  int_code_e int_code;

  // Timer match is sticky until mtimecmp is rewritten, msip is a level
  always_comb begin
    mip_next      = mip;
    mip_next.mtip = mip.mtip | timer_int;
    mip_next.msip = soft_int;
  end
  assign mip_rup = timer_int | (mip.msip != soft_int);

  always_comb begin
    exception  = 1'b1;
    addr_fault = 1'b1;
    ex_code    = EX_INSN_MISALIGNED;
    if (mal_insn) begin
      ex_code = EX_INSN_MISALIGNED;
    end else if (fault_insn) begin
      ex_code = EX_INSN_FAULT;
    end else if (illegal_insn) begin
      ex_code    = EX_ILLEGAL_INSN;
      addr_fault = 1'b0;
    end else if (breakpoint) begin
      ex_code    = EX_BREAKPOINT;
      addr_fault = 1'b0;
    end else if (env_m) begin
      ex_code    = EX_ENV_CALL_M;
      addr_fault = 1'b0;
    end else if (mal_l) begin
      ex_code = EX_LOAD_MISALIGNED;
    end else if (fault_l) begin
      ex_code = EX_LOAD_FAULT;
    end else if (mal_s) begin
      ex_code = EX_STORE_MISALIGNED;
    end else if (fault_s) begin
      ex_code = EX_STORE_FAULT;
    end else begin
      exception  = 1'b0;
      addr_fault = 1'b0;
    end
  end

  // Timer beats software
  assign int_code = (mie.mtie & mip.mtip) ? INT_TIMER : INT_SOFT;
  assign int_pend = mstatus.ie & ((mie.mtie & mip.mtip) | (mie.msie & mip.msip));

  assign intr = int_pend & ~exception;
  assign trap = exception | int_pend;

  assign mepc_rup  = trap;
  assign mepc_next = epc;

  assign mcause_rup            = trap;
  assign mcause_next.interrupt = ~exception;
  assign mcause_next.cause     = exception ? 31'(ex_code) : 31'(int_code);

  assign mbadaddr_rup  = exception & addr_fault;
  assign mbadaddr_next = badaddr;

  // Trap disables interrupts, mret enables them again
  always_comb begin
    mstatus_next    = mstatus;
    mstatus_next.ie = ~trap;
  end
  assign mstatus_rup = trap | mret;

  assign insert_pc = trap | mret;
  assign priv_pc   = trap ? mtvec : mepc;

  a_mret_no_fault: assert property (@(posedge CLK) disable iff (!nRST)
    mret |-> !(mal_insn | fault_insn | illegal_insn | breakpoint | env_m |
               mal_l | fault_l | mal_s | fault_s))
    else $error("prv_control: mret together with a fault strobe");

endmodule

`default_nettype wire

// ==== design/csr_rfile.sv ====
// Machine mode CSR register file
//   read mux and invalid address detect
//   swap/set/clear read-modify-write
//   trap-side updates from prv_control, which win over pipeline writes
//   mtime, cycle and instret counters with timer compare

`timescale 1ns/1ps
`default_nettype none

`include "rv_priv_params.svh"

module csr_rfile
  import rv32i_types_pkg::*, machine_mode_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t csr_addr,
  input  logic      csr_swap,
  input  logic      csr_set,
  input  logic      csr_clr,
  input  word_t     csr_wdata,
  output word_t     csr_rdata,
  output logic      invalid_csr,
  input  logic      instr_retired,
  input  logic      mstatus_rup,
  input  mstatus_t  mstatus_next,
  input  logic      mepc_rup,
  input  word_t     mepc_next,
  input  logic      mcause_rup,
  input  mcause_t   mcause_next,
  input  logic      mbadaddr_rup,
  input  word_t     mbadaddr_next,
  input  logic      mip_rup,
  input  mip_t      mip_next,
  output mstatus_t  mstatus,
  output mie_t      mie,
  output mip_t      mip,
  output word_t     mepc,
  output word_t     mtvec,
  output logic      timer_int
);

  logic        csr_req;
  logic        addr_valid;
  logic        csr_wen;
  logic        mtime_wr_lo, mtime_wr_hi;
  word_t       rup_data;
  mstatus_t    mstatus_wr;
  mie_t        mie_wr;
  mcpuid_t     mcpuid;
  logic        ie_q, msie_q, mtie_q, msip_q, mtip_q;
  word_t       mscratch_q, mepc_q, mbadaddr_q;
  word_t       mtimecmp_q, mtohost_q, mfromhost_q;
  mcause_t     mcause_q;
  logic [63:0] mtime_count, cycle_count, instret_count;

  function automatic logic csr_wr_hit(csr_addr_e target);
    return csr_wen && (csr_addr == target);
  endfunction

  assign csr_req     = csr_swap | csr_set | csr_clr;
  assign invalid_csr = csr_req & ~addr_valid;
  assign csr_wen     = csr_req & addr_valid; // Unknown addresses write nothing

  assign mtime_wr_lo = csr_wen && (csr_addr == MTIME_ADDR);
  assign mtime_wr_hi = csr_wen && (csr_addr == MTIMEH_ADDR);

  // New value from the old one in csr_rdata
  assign rup_data = csr_swap ? csr_wdata :
                    csr_set  ? (csr_rdata | csr_wdata) :
                               (csr_rdata & ~csr_wdata);

  assign mstatus_wr = mstatus_t'(rup_data);
  assign mie_wr     = mie_t'(rup_data);

  assign mcpuid.base       = 2'b00;
  assign mcpuid.zero       = '0;
  assign mcpuid.extensions = 26'h000_0100; // I only

  // Machine mode only, ie is the sole live bit
  always_comb begin
    mstatus      = '0;
    mstatus.prv  = M_MODE;
    mstatus.prv1 = M_MODE;
    mstatus.prv2 = M_MODE;
    mstatus.prv3 = M_MODE;
    mstatus.ie   = ie_q;
  end

  always_comb begin
    mie      = '0;
    mie.msie = msie_q;
    mie.mtie = mtie_q;
    mip      = '0;
    mip.msip = msip_q;
    mip.mtip = mtip_q;
  end

  assign mepc      = mepc_q;
  assign mtvec     = `RV_MTVEC_ADDR;
  assign timer_int = (mtime_count[31:0] == mtimecmp_q);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ie_q        <= `RV_IE_RESET;
      msie_q      <= 1'b0;
      mtie_q      <= 1'b0;
      msip_q      <= 1'b0;
      mtip_q      <= 1'b0;
      mscratch_q  <= '0;
      mepc_q      <= '0;
      mcause_q    <= '0;
      mbadaddr_q  <= '0;
      mtimecmp_q  <= '0;
      mtohost_q   <= '0;
      mfromhost_q <= '0;
    end else begin
      if (mstatus_rup) ie_q <= mstatus_next.ie;
      else if (csr_wr_hit(MSTATUS_ADDR)) ie_q <= mstatus_wr.ie;

      if (csr_wr_hit(MIE_ADDR)) begin
        msie_q <= mie_wr.msie;
        mtie_q <= mie_wr.mtie;
      end

      if (mepc_rup) mepc_q <= mepc_next;
      else if (csr_wr_hit(MEPC_ADDR)) mepc_q <= rup_data;

      if (mcause_rup) mcause_q <= mcause_next;
      else if (csr_wr_hit(MCAUSE_ADDR)) mcause_q <= mcause_t'(rup_data);

      if (mbadaddr_rup) mbadaddr_q <= mbadaddr_next;
      else if (csr_wr_hit(MBADADDR_ADDR)) mbadaddr_q <= rup_data;

      // New compare value acknowledges the timer interrupt
      if (csr_wr_hit(MTIMECMP_ADDR)) mtip_q <= 1'b0;
      else if (mip_rup) mtip_q <= mip_next.mtip;
      if (mip_rup) msip_q <= mip_next.msip;

      if (csr_wr_hit(MSCRATCH_ADDR))  mscratch_q  <= rup_data;
      if (csr_wr_hit(MTIMECMP_ADDR))  mtimecmp_q  <= rup_data;
      if (csr_wr_hit(MTOHOST_ADDR))   mtohost_q   <= rup_data;
      if (csr_wr_hit(MFROMHOST_ADDR)) mfromhost_q <= rup_data;
    end
  end

  csr_counter64 mtime_cnt (   // Also read back as time/timeh
    .CLK(CLK), .nRST(nRST), .inc(1'b1),
    .wr_lo(mtime_wr_lo), .wr_hi(mtime_wr_hi),
    .wdata(rup_data), .count(mtime_count)
  );

  csr_counter64 cycle_cnt (
    .CLK(CLK), .nRST(nRST), .inc(1'b1), .wr_lo(1'b0), .wr_hi(1'b0),
    .wdata(rup_data), .count(cycle_count)
  );

  csr_counter64 instret_cnt (
    .CLK(CLK), .nRST(nRST), .inc(instr_retired), .wr_lo(1'b0), .wr_hi(1'b0),
    .wdata(rup_data), .count(instret_count)
  );

  always_comb begin
    addr_valid = 1'b1;
    case (csr_addr)
      MCPUID_ADDR:    csr_rdata = word_t'(mcpuid);
      MIMPID_ADDR:    csr_rdata = '0;
      MHARTID_ADDR:   csr_rdata = `RV_HART_ID;
      MSTATUS_ADDR:   csr_rdata = word_t'(mstatus);
      MTVEC_ADDR:     csr_rdata = mtvec;
      MTDELEG_ADDR:   csr_rdata = '0; // No delegation
      MIE_ADDR:       csr_rdata = word_t'(mie);
      MTIMECMP_ADDR:  csr_rdata = mtimecmp_q;
      MSCRATCH_ADDR:  csr_rdata = mscratch_q;
      MEPC_ADDR:      csr_rdata = mepc_q;
      MCAUSE_ADDR:    csr_rdata = word_t'(mcause_q);
      MBADADDR_ADDR:  csr_rdata = mbadaddr_q;
      MIP_ADDR:       csr_rdata = word_t'(mip);
      MTIME_ADDR,
      TIME_ADDR:      csr_rdata = mtime_count[31:0];
      MTIMEH_ADDR,
      TIMEH_ADDR:     csr_rdata = mtime_count[63:32];
      MTOHOST_ADDR:   csr_rdata = mtohost_q;
      MFROMHOST_ADDR: csr_rdata = mfromhost_q;
      CYCLE_ADDR:     csr_rdata = cycle_count[31:0];
      CYCLEH_ADDR:    csr_rdata = cycle_count[63:32];
      INSTRET_ADDR:   csr_rdata = instret_count[31:0];
      INSTRETH_ADDR:  csr_rdata = instret_count[63:32];
      default: begin
        addr_valid = 1'b0;
        csr_rdata  = '0;
      end
    endcase
  end

  // Pipeline decode drives at most one CSR operation
  a_csr_op_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({csr_swap, csr_set, csr_clr}))
    else $error("csr_rfile: more than one of swap/set/clr asserted");

  // Decode presents a real address with every request
  a_req_addr_known: assert property (@(posedge CLK) disable iff (!nRST)
    csr_req |-> !$isunknown(csr_addr))
    else $error("csr_rfile: CSR request with an unknown address");

endmodule

`default_nettype wire

// ==== design/csr_counter64.sv ====
// 64-bit CSR counter
//   increments when enabled
//   low and high halves can be loaded separately

`timescale 1ns/1ps
`default_nettype none

module csr_counter64
  import rv32i_types_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  logic        inc,
  input  logic        wr_lo,
  input  logic        wr_hi,
  input  word_t       wdata,
  output logic [63:0] count
);

  logic [63:0] count_inc;

  assign count_inc = count + {63'd0, inc};

  // A loaded half replaces its bits, the other half still counts
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else begin
      count[31:0]  <= wr_lo ? wdata : count_inc[31:0];
      count[63:32] <= wr_hi ? wdata : count_inc[63:32];
    end
  end

endmodule

`default_nettype wire

// ==== design/machine_mode_types_pkg.sv ====
// Machine mode CSR definitions, 1.7 privileged layout
//   CSR address map
//   mcpuid, mstatus, mie, mip and mcause layouts
//   exception and interrupt cause codes

`default_nettype none

package machine_mode_types_pkg;

  localparam logic [1:0] M_MODE = 2'b11;

  typedef enum logic [11:0] {
    MCPUID_ADDR    = 12'hf00,
    MIMPID_ADDR    = 12'hf01,
    MHARTID_ADDR   = 12'hf10,
    MSTATUS_ADDR   = 12'h300,
    MTVEC_ADDR     = 12'h301,
    MTDELEG_ADDR   = 12'h302,
    MIE_ADDR       = 12'h304,
    MTIMECMP_ADDR  = 12'h321,
    MSCRATCH_ADDR  = 12'h340,
    MEPC_ADDR      = 12'h341,
    MCAUSE_ADDR    = 12'h342,
    MBADADDR_ADDR  = 12'h343,
    MIP_ADDR       = 12'h344,
    MTIME_ADDR     = 12'h701,
    MTIMEH_ADDR    = 12'h741,
    MTOHOST_ADDR   = 12'h780, // Non-standard host registers
    MFROMHOST_ADDR = 12'h781,
    CYCLE_ADDR     = 12'hc00,
    TIME_ADDR      = 12'hc01,
    INSTRET_ADDR   = 12'hc02,
    CYCLEH_ADDR    = 12'hc80,
    TIMEH_ADDR     = 12'hc81,
    INSTRETH_ADDR  = 12'hc82
  } csr_addr_e;

  typedef struct packed {
    logic [1:0]  base;       // 0 means RV32
    logic [3:0]  zero;
    logic [25:0] extensions; // One bit per letter
  } mcpuid_t;

  typedef struct packed {
    logic       sd;
    logic [8:0] zero;
    logic [4:0] vm;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] prv3;
    logic       ie3;
    logic [1:0] prv2;
    logic       ie2;
    logic [1:0] prv1;
    logic       ie1;
    logic [1:0] prv;
    logic       ie;
  } mstatus_t;

  // Interrupt enable, bit positions match mip_t
  typedef struct packed {
    logic [23:0] zero_2;
    logic        mtie;
    logic        htie;
    logic        stie;
    logic        zero_1;
    logic        msie;
    logic        hsie;
    logic        ssie;
    logic        zero_0;
  } mie_t;

  typedef struct packed {
    logic [23:0] zero_2;
    logic        mtip;
    logic        htip;
    logic        stip;
    logic        zero_1;
    logic        msip;
    logic        hsip;
    logic        ssip;
    logic        zero_0;
  } mip_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] cause;
  } mcause_t;

  typedef enum logic [31:0] {
    EX_INSN_MISALIGNED  = 32'd0,
    EX_INSN_FAULT       = 32'd1,
    EX_ILLEGAL_INSN     = 32'd2,
    EX_BREAKPOINT       = 32'd3,
    EX_LOAD_MISALIGNED  = 32'd4,
    EX_LOAD_FAULT       = 32'd5,
    EX_STORE_MISALIGNED = 32'd6,
    EX_STORE_FAULT      = 32'd7,
    EX_ENV_CALL_M       = 32'd11
  } ex_code_e;

  typedef enum logic [31:0] {
    INT_SOFT  = 32'd3,
    INT_TIMER = 32'd7
  } int_code_e;

endpackage

`default_nettype wire

// ==== design/rv32i_types_pkg.sv ====
// Core-wide base types for the RV32I pipeline
//   word_t      32-bit data word
//   csr_addr_t  12-bit CSR address field

`default_nettype none

package rv32i_types_pkg;

  localparam int WORD_W     = 32;
  localparam int CSR_ADDR_W = 12;

  // Data and address word
  typedef logic [WORD_W-1:0] word_t;

  // Raw CSR address as decoded from the instruction
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

endpackage

`default_nettype wire

// ==== design/rv_priv_params.svh ====
// Build-time constants for the machine mode privilege unit
//   trap vector address
//   hart id returned by mhartid
//   reset value of the global interrupt enable

`ifndef RV_PRIV_PARAMS_SVH
`define RV_PRIV_PARAMS_SVH

// Fixed trap entry point, mtvec is read-only
`define RV_MTVEC_ADDR 32'h0000_01c0

// Single hart system
`define RV_HART_ID 32'd0

`define RV_IE_RESET 1'b1 // Interrupts globally enabled out of reset

`endif
